//--- design/periph_config.svh
// Widths, counts and address map of the peripheral subsystem.
// Device field is address bits 15:12; NUM_TIMERS must be a power of two.
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Register bus
`define REG_ADDR_W        16
`define REG_DATA_W        32
`define DEV_SEL_LSB       12
`define DEV_SEL_W         (`REG_ADDR_W - `DEV_SEL_LSB)
`define DEV_PLIC          4'd0
`define DEV_TIMER         4'd1
`define ERR_RDATA         32'hdeadbeef

// Interrupt sources and targets
`define NUM_SOURCES       8
`define NUM_EXT_SOURCES   5
`define NUM_TARGETS       2
`define PRIO_W            3
`define NUM_TIMERS        2

// Register offsets inside a device
`define PLIC_PENDING_OFS  12'h080
`define PLIC_ENABLE_OFS   12'h100
`define PLIC_THRESH_OFS   12'h200
`define PLIC_CLAIM_OFS    12'h280
`define TIMER_STRIDE_LSB  4

`endif

//--- design/reg_bus_pkg.sv
// Register bus types. Strobe protocol without back-pressure,
// every request is answered exactly one cycle later.
`include "periph_config.svh"

package reg_bus_pkg;

    // -------------------------------------------------------------------------
    // Request from the bus master
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic                   valid;   // One-cycle strobe
        logic                   write;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`REG_DATA_W-1:0] wdata;
    } reg_req_t;

    // -------------------------------------------------------------------------
    // Response from the answering device
    // -------------------------------------------------------------------------
    typedef struct packed {
        logic                   valid;   // One cycle after the request
        logic                   error;
        logic [`REG_DATA_W-1:0] rdata;   // Zero on writes
    } reg_rsp_t;

endpackage

//--- design/irq_pkg.sv
// Interrupt controller types. Source 0 is reserved and means no interrupt.
`include "periph_config.svh"

package irq_pkg;

    // Single source id and priority
    typedef logic [$clog2(`NUM_SOURCES)-1:0] src_id_t;
    typedef logic [`PRIO_W-1:0]              prio_t;

    // One bit per source
    typedef logic [`NUM_SOURCES-1:0]         src_vec_t;

    // Priority of every source
    typedef prio_t [`NUM_SOURCES-1:0]        prio_table_t;

    // Per target: source mask, threshold and claim id
    typedef src_vec_t [`NUM_TARGETS-1:0]     target_enable_t;
    typedef prio_t    [`NUM_TARGETS-1:0]     target_prio_t;
    typedef src_id_t  [`NUM_TARGETS-1:0]     target_id_t;

endpackage

//--- design/reg_demux.sv
// Routes each request to one device by the address device field.
// Unmapped device fields go to the error responder.
`timescale 1ns/1ps
`include "periph_config.svh"

module reg_demux
    import reg_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  reg_req_t req_i,
    output reg_rsp_t rsp_o,
    output reg_req_t plic_req_o,
    output reg_req_t timer_req_o,
    output reg_req_t err_req_o,
    input  reg_rsp_t plic_rsp_i,
    input  reg_rsp_t timer_rsp_i,
    input  reg_rsp_t err_rsp_i
);

    localparam int dev_plic  = 0;
    localparam int dev_timer = 1;
    localparam int dev_err   = 2;

    logic [`DEV_SEL_W-1:0] dev_sel;
    logic [2:0]            hit;
    logic [2:0]            sel_q;

    assign dev_sel = req_i.addr[`DEV_SEL_LSB +: `DEV_SEL_W];

    // Exactly one device is hit for any address
    always_comb begin
        hit = '0;
        if (dev_sel == `DEV_PLIC) begin
            hit[dev_plic] = 1'b1;
        end else if (dev_sel == `DEV_TIMER) begin
            hit[dev_timer] = 1'b1;
        end else begin
            hit[dev_err] = 1'b1;
        end
    end

    always_comb begin
        plic_req_o        = req_i;
        plic_req_o.valid  = req_i.valid & hit[dev_plic];
        timer_req_o       = req_i;
        timer_req_o.valid = req_i.valid & hit[dev_timer];
        err_req_o         = req_i;
        err_req_o.valid   = req_i.valid & hit[dev_err];
    end

    // Remember which device owes the response in the next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sel_q <= '0;
        end else begin
            sel_q <= hit & {3{req_i.valid}};
        end
    end

    always_comb begin
        rsp_o = '0;
        if (plic_rsp_i.valid && sel_q[dev_plic]) begin
            rsp_o = plic_rsp_i;
        end else if (timer_rsp_i.valid && sel_q[dev_timer]) begin
            rsp_o = timer_rsp_i;
        end else if (err_rsp_i.valid && sel_q[dev_err]) begin
            rsp_o = err_rsp_i;
        end
    end

endmodule

//--- design/err_responder.sv
// Answers every access with an error. Reads return ERR_RDATA.
`timescale 1ns/1ps
`include "periph_config.svh"

module err_responder
    import reg_bus_pkg::*;
(
    input  logic     clk_i,
    input  logic     reset_i,
    input  reg_req_t req_i,
    output reg_rsp_t rsp_o
);

    logic                   valid_q;
    logic [`REG_DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            rdata_q <= req_i.write ? '0 : `ERR_RDATA;
        end
    end

    assign rsp_o = '{valid: valid_q, error: 1'b1, rdata: rdata_q};

endmodule

//--- design/periph_timer.sv
// Free-running compare timers, one register block of 0x10 bytes per timer.
// Interrupt level is registered and stays high while count >= compare.
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_timer
    import reg_bus_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  reg_req_t               req_i,
    output reg_rsp_t               rsp_o,
    output logic [`NUM_TIMERS-1:0] irq_o
);

    localparam int data_w = `REG_DATA_W;
    localparam int idx_w  = $clog2(`NUM_TIMERS);
    localparam int idx_lsb = `TIMER_STRIDE_LSB;

    typedef struct packed {
        logic              enable;
        logic [data_w-1:0] compare;
        logic [data_w-1:0] count;
    } timer_t;

    timer_t [`NUM_TIMERS-1:0] tmr_q;
    logic   [`NUM_TIMERS-1:0] irq_q;
    logic [`DEV_SEL_LSB-1:0]  offset;
    logic [idx_w-1:0]         idx;
    logic                     sel_cnt, sel_ctrl, sel_cmp;
    logic                     wr_en;
    logic [data_w-1:0]        rd_data;
    logic                     valid_q;
    logic                     error_q;
    logic [data_w-1:0]        rdata_q;

    assign offset = req_i.addr[`DEV_SEL_LSB-1:0];
    assign idx    = offset[idx_lsb +: idx_w];
    assign wr_en  = req_i.valid & req_i.write;

    // Counter 0x0, control 0x4, compare 0x8 inside each block
    always_comb begin
        sel_cnt  = 1'b0;
        sel_ctrl = 1'b0;
        sel_cmp  = 1'b0;
        if (offset[`DEV_SEL_LSB-1:idx_lsb+idx_w] == '0) begin
            case (offset[idx_lsb-1:0])
                4'h0:    sel_cnt  = 1'b1;
                4'h4:    sel_ctrl = 1'b1;
                4'h8:    sel_cmp  = 1'b1;
                default: ;
            endcase
        end
        rd_data = '0;
        if (sel_cnt)  rd_data = tmr_q[idx].count;
        if (sel_ctrl) rd_data[0] = tmr_q[idx].enable;
        if (sel_cmp)  rd_data = tmr_q[idx].compare;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int t = 0; t < `NUM_TIMERS; t++) begin
                tmr_q[t].enable  <= 1'b0;
                tmr_q[t].count   <= '0;
                tmr_q[t].compare <= '1;
            end
            irq_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            for (int t = 0; t < `NUM_TIMERS; t++) begin
                if (tmr_q[t].enable) tmr_q[t].count <= tmr_q[t].count + 1'b1;
                irq_q[t] <= tmr_q[t].enable && (tmr_q[t].count >= tmr_q[t].compare);
            end
            // A bus write overrides the increment of the same cycle
            if (wr_en && sel_cnt)  tmr_q[idx].count   <= req_i.wdata;
            if (wr_en && sel_ctrl) tmr_q[idx].enable  <= req_i.wdata[0];
            if (wr_en && sel_cmp)  tmr_q[idx].compare <= req_i.wdata;
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            error_q <= !(sel_cnt | sel_ctrl | sel_cmp);
            rdata_q <= req_i.write ? '0 : rd_data;
        end
    end

    assign rsp_o = '{valid: valid_q, error: error_q, rdata: rdata_q};
    assign irq_o = irq_q;

endmodule

//--- design/plic_regs.sv
// Interrupt controller register file. Pending and claim are read-only,
// a claim read reports the current best source and has no side effect.
`timescale 1ns/1ps
`include "periph_config.svh"

module plic_regs
    import reg_bus_pkg::*;
    import irq_pkg::*;
(
    input  logic           clk_i,
    input  logic           reset_i,
    input  reg_req_t       req_i,
    output reg_rsp_t       rsp_o,
    input  src_vec_t       sources_i,
    input  target_id_t     claim_id_i,
    output prio_table_t    prio_o,
    output target_enable_t enable_o,
    output target_prio_t   threshold_o
);

    prio_table_t              prio_q;
    target_enable_t           en_q;
    target_prio_t             thr_q;
    logic [`DEV_SEL_LSB-1:0]  offset;
    logic [`NUM_SOURCES-1:0]  prio_sel;
    logic [`NUM_TARGETS-1:0]  en_sel, thr_sel;
    logic                     legal, read_only, wr_en;
    logic [`REG_DATA_W-1:0]   rd_data;
    logic                     valid_q;
    logic                     error_q;
    logic [`REG_DATA_W-1:0]   rdata_q;

    assign offset = req_i.addr[`DEV_SEL_LSB-1:0];
    assign wr_en  = req_i.valid & req_i.write;

    // ------------------------------------------------------------------------
    // Address decode and read mux
    // ------------------------------------------------------------------------
    always_comb begin
        prio_sel  = '0;
        en_sel    = '0;
        thr_sel   = '0;
        legal     = 1'b0;
        read_only = 1'b0;
        rd_data   = '0;
        for (int s = 0; s < `NUM_SOURCES; s++) begin
            if (offset == 4 * s) begin
                prio_sel[s]              = 1'b1;
                legal                    = 1'b1;
                rd_data[`PRIO_W-1:0]     = prio_q[s];
            end
        end
        if (offset == `PLIC_PENDING_OFS) begin
            legal                        = 1'b1;
            read_only                    = 1'b1;
            rd_data[`NUM_SOURCES-1:0]    = sources_i;
        end
        for (int t = 0; t < `NUM_TARGETS; t++) begin
            if (offset == `PLIC_ENABLE_OFS + 4 * t) begin
                en_sel[t]                 = 1'b1;
                legal                     = 1'b1;
                rd_data[`NUM_SOURCES-1:0] = en_q[t];
            end
            if (offset == `PLIC_THRESH_OFS + 4 * t) begin
                thr_sel[t]                = 1'b1;
                legal                     = 1'b1;
                rd_data[`PRIO_W-1:0]      = thr_q[t];
            end
            if (offset == `PLIC_CLAIM_OFS + 4 * t) begin
                legal                     = 1'b1;
                read_only                 = 1'b1;
                rd_data[$bits(src_id_t)-1:0] = claim_id_i[t];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            prio_q  <= '0;
            en_q    <= '0;
            thr_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            // Source 0 keeps priority 0, its writes are dropped
            for (int s = 0; s < `NUM_SOURCES; s++) begin
                if (wr_en && prio_sel[s] && s != 0) prio_q[s] <= req_i.wdata[`PRIO_W-1:0];
            end
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                if (wr_en && en_sel[t])  en_q[t]  <= req_i.wdata[`NUM_SOURCES-1:0];
                if (wr_en && thr_sel[t]) thr_q[t] <= req_i.wdata[`PRIO_W-1:0];
            end
            valid_q <= req_i.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.valid) begin
            error_q <= !legal || (req_i.write && read_only);
            rdata_q <= req_i.write ? '0 : rd_data;
        end
    end

    assign rsp_o       = '{valid: valid_q, error: error_q, rdata: rdata_q};
    assign prio_o      = prio_q;
    assign enable_o    = en_q;
    assign threshold_o = thr_q;

endmodule

//--- design/plic_target.sv
// Picks the best pending source for one target. Ties go to the lowest id,
// a source must be strictly above the threshold to qualify.
`timescale 1ns/1ps
`include "periph_config.svh"

module plic_target
    import irq_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  src_vec_t    sources_i,
    input  prio_table_t prio_i,
    input  src_vec_t    enable_i,
    input  prio_t       threshold_i,
    output src_id_t     claim_id_o,
    output logic        eip_o
);

    src_id_t best_id;
    prio_t   best_prio;
    logic    eip_q;

    // ------------------------------------------------------------------------
    // Priority search
    // ------------------------------------------------------------------------
    // Starting from the threshold makes the strict compare do both jobs.
    // Ascending scan keeps the first source of equal priority.
    always_comb begin
        best_id   = '0;
        best_prio = threshold_i;
        for (int s = 1; s < `NUM_SOURCES; s++) begin
            if (sources_i[s] && enable_i[s] && (prio_i[s] > best_prio)) begin
                best_id   = src_id_t'(s);
                best_prio = prio_i[s];
            end
        end
    end

    // Interrupt line follows one cycle after the sources
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            eip_q <= 1'b0;
        end else begin
            eip_q <= (best_id != '0);
        end
    end

    assign claim_id_o = best_id;
    assign eip_o      = eip_q;

endmodule

//--- design/periph_subsystem.sv
// Peripheral subsystem: interrupt controller, two timers and error responder
// behind one register bus. External sources are level-triggered, ids 3 to 7.
`timescale 1ns/1ps
`include "periph_config.svh"

module periph_subsystem
    import reg_bus_pkg::*;
    import irq_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  reg_req_t                    req_i,
    output reg_rsp_t                    rsp_o,
    input  logic [`NUM_EXT_SOURCES-1:0] irq_sources_i,
    output logic [`NUM_TARGETS-1:0]     irq_o
);

    reg_req_t               plic_req, timer_req, err_req;
    reg_rsp_t               plic_rsp, timer_rsp, err_rsp;
    logic [`NUM_TIMERS-1:0] timer_irq;
    src_vec_t               sources;
    prio_table_t            prio;
    target_enable_t         enable;
    target_prio_t           threshold;
    target_id_t             claim_id;

    // Id 0 is never pending, timers sit at ids 1 and 2
    assign sources = {irq_sources_i, timer_irq, 1'b0};

    reg_demux i_reg_demux (
        .clk_i       ( clk_i     ),
        .reset_i     ( reset_i   ),
        .req_i       ( req_i     ),
        .rsp_o       ( rsp_o     ),
        .plic_req_o  ( plic_req  ),
        .timer_req_o ( timer_req ),
        .err_req_o   ( err_req   ),
        .plic_rsp_i  ( plic_rsp  ),
        .timer_rsp_i ( timer_rsp ),
        .err_rsp_i   ( err_rsp   )
    );

    plic_regs i_plic_regs (
        .clk_i       ( clk_i     ),
        .reset_i     ( reset_i   ),
        .req_i       ( plic_req  ),
        .rsp_o       ( plic_rsp  ),
        .sources_i   ( sources   ),
        .claim_id_i  ( claim_id  ),
        .prio_o      ( prio      ),
        .enable_o    ( enable    ),
        .threshold_o ( threshold )
    );

    periph_timer i_periph_timer (
        .clk_i   ( clk_i     ),
        .reset_i ( reset_i   ),
        .req_i   ( timer_req ),
        .rsp_o   ( timer_rsp ),
        .irq_o   ( timer_irq )
    );

    err_responder i_err_responder (
        .clk_i   ( clk_i   ),
        .reset_i ( reset_i ),
        .req_i   ( err_req ),
        .rsp_o   ( err_rsp )
    );

    for (genvar t = 0; t < `NUM_TARGETS; t++) begin : gen_target
        plic_target i_plic_target (
            .clk_i       ( clk_i        ),
            .reset_i     ( reset_i      ),
            .sources_i   ( sources      ),
            .prio_i      ( prio         ),
            .enable_i    ( enable[t]    ),
            .threshold_i ( threshold[t] ),
            .claim_id_o  ( claim_id[t]  ),
            .eip_o       ( irq_o[t]     )
        );
    end

endmodule

//--- sim/tb_clock.sv
// 10 ns clock from time 0, reset held high for the first 10 rising edges
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #5 clk_o = ~clk_o;
    end

    // Release just after the edge, like every other driven input
    initial begin
        repeat (10) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

//--- sim/tb_checker.sv
// Compares every bus response with the oldest posted expectation.
// The source model holds the external inputs only, timer sources count as idle.
`timescale 1ns/1ps
`include "periph_config.svh"

module tb_checker
    import reg_bus_pkg::*;
    import irq_pkg::*;
(
    input logic                    clk_i,
    input reg_rsp_t                rsp_i,
    input logic [`NUM_TARGETS-1:0] irq_i
);

    localparam logic [1:0] mode_exact    = 2'd0;
    localparam logic [1:0] mode_at_least = 2'd1;

    typedef struct packed {
        logic [1:0]             mode;
        logic                   error;
        logic [`REG_DATA_W-1:0] rdata;
    } expect_t;

    expect_t        exp_q[$];
    string          name_q[$];
    int             outstanding  = 0;
    int             error_count  = 0;
    int             test_errors  = 0;
    int             tests_passed = 0;
    int             tests_failed = 0;
    string          test_name    = "none";
    src_vec_t       model_src    = '0;
    prio_table_t    model_prio   = '0;
    target_enable_t model_en     = '0;
    target_prio_t   model_thr    = '0;

    // ------------------------------------------------------------------------
    // Reference model of one interrupt target
    // ------------------------------------------------------------------------
    // Highest priority wins, lowest id on a tie, strictly above threshold
    function automatic src_id_t ref_claim(input int t);
        src_id_t best;
        prio_t   best_prio;
        logic    found;
        best      = '0;
        best_prio = '0;
        found     = 1'b0;
        for (int s = 1; s < `NUM_SOURCES; s++) begin
            if (model_src[s] && model_en[t][s] && (model_prio[s] > model_thr[t])) begin
                if (!found || (model_prio[s] > best_prio)) begin
                    best      = src_id_t'(s);
                    best_prio = model_prio[s];
                    found     = 1'b1;
                end
            end
        end
        return best;
    endfunction

    task automatic note_error(input string msg);
        $display("%s", msg);
        error_count++;
        test_errors++;
    endtask

    task automatic push_expect(input string name, input logic [1:0] mode, input logic error,
                               input logic [`REG_DATA_W-1:0] rdata);
        expect_t item;
        item.mode  = mode;
        item.error = error;
        item.rdata = rdata;
        exp_q.push_back(item);
        name_q.push_back(name);
        outstanding++;
    endtask

    task automatic post_exact(input string name, input logic error,
                              input logic [`REG_DATA_W-1:0] rdata);
        push_expect(name, mode_exact, error, rdata);
    endtask

    task automatic post_at_least(input string name, input logic [`REG_DATA_W-1:0] rdata);
        push_expect(name, mode_at_least, 1'b0, rdata);
    endtask

    task automatic post_claim(input string name, input int t);
        logic [`REG_DATA_W-1:0] data;
        data = '0;
        data[$bits(src_id_t)-1:0] = ref_claim(t);
        push_expect(name, mode_exact, 1'b0, data);
    endtask

    // Model updates, applied once the DUT write has been answered
    task automatic track_prio(input int s, input prio_t v);
        model_prio[s] = v;
    endtask

    task automatic track_enable(input int t, input src_vec_t v);
        model_en[t] = v;
    endtask

    task automatic track_threshold(input int t, input prio_t v);
        model_thr[t] = v;
    endtask

    task automatic track_ext(input logic [`NUM_EXT_SOURCES-1:0] v);
        model_src = {v, 3'b000};
    endtask

    // ------------------------------------------------------------------------
    // Response compare, sampled mid-cycle where rsp_i is stable
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        expect_t cur;
        string   name;
        if (rsp_i.valid) begin
            if (exp_q.size() == 0) begin
                note_error($sformatf("%s: a response arrived with no request outstanding",
                                     test_name));
            end else begin
                cur  = exp_q.pop_front();
                name = name_q.pop_front();
                outstanding--;
                if (rsp_i.error !== cur.error) begin
                    note_error($sformatf("[FAIL] %s, %s: expected error %0b, actual %0b",
                                         test_name, name, cur.error, rsp_i.error));
                end else if (cur.mode == mode_exact && rsp_i.rdata !== cur.rdata) begin
                    note_error($sformatf("[FAIL] %s, %s: expected %h, actual %h",
                                         test_name, name, cur.rdata, rsp_i.rdata));
                end else if (cur.mode == mode_at_least && rsp_i.rdata < cur.rdata) begin
                    note_error($sformatf("[FAIL] %s, %s: expected at least %0d, actual %0d",
                                         test_name, name, cur.rdata, rsp_i.rdata));
                end
            end
        end
    end

    task automatic wait_response(input string name);
        int cycles;
        cycles = 0;
        while (outstanding != 0 && cycles < 100) begin
            @(posedge clk_i);
            cycles++;
        end
        if (outstanding != 0) begin
            note_error($sformatf("%s, %s: no response within 100 cycles", test_name, name));
            exp_q.delete();
            name_q.delete();
            outstanding = 0;
        end
    endtask

    task automatic wait_irq(input string name, input int t, input logic level);
        int cycles;
        cycles = 0;
        while (irq_i[t] !== level && cycles < 100) begin
            @(negedge clk_i);
            cycles++;
        end
        if (irq_i[t] !== level) begin
            note_error($sformatf("%s, %s: irq_o[%0d] did not go to %0b within 100 cycles",
                                 test_name, name, t, level));
        end
    endtask

    task automatic check_irq(input string name, input int t, input logic level);
        @(negedge clk_i);
        if (irq_i[t] !== level) begin
            note_error($sformatf("[FAIL] %s, %s: expected %0b, actual %0b",
                                 test_name, name, level, irq_i[t]));
        end
    endtask

    task automatic check_irq_model(input string name, input int t);
        check_irq(name, t, ref_claim(t) != '0);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s passed", test_name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", test_name, test_errors);
        end
    endtask

    task automatic print_summary();
        if (outstanding != 0) begin
            note_error("Responses were still outstanding at the end of the run");
        end
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, error_count);
    endtask

endmodule

//--- sim/tb_periph_subsystem.sv
// Testbench top. Inputs change 1 ns after the rising edge, all compares
// happen in tb_checker. Timers stay disabled outside the timer test.
`timescale 1ns/1ps
`include "periph_config.svh"

module tb_periph_subsystem
    import reg_bus_pkg::*;
    import irq_pkg::*;
();

    localparam logic [15:0] plic_base  = 16'h0000;
    localparam logic [15:0] timer_base = 16'h1000;
    localparam logic [15:0] unmapped   = 16'h5000;

    logic                        clk;
    logic                        reset;
    reg_req_t                    req;
    reg_rsp_t                    rsp;
    logic [`NUM_EXT_SOURCES-1:0] ext_irq;
    logic [`NUM_TARGETS-1:0]     irq;
    integer                      seed;

    tb_clock i_tb_clock (
        .clk_o   ( clk   ),
        .reset_o ( reset )
    );

    periph_subsystem i_periph_subsystem (
        .clk_i         ( clk     ),
        .reset_i       ( reset   ),
        .req_i         ( req     ),
        .rsp_o         ( rsp     ),
        .irq_sources_i ( ext_irq ),
        .irq_o         ( irq     )
    );

    tb_checker i_checker (
        .clk_i ( clk ),
        .rsp_i ( rsp ),
        .irq_i ( irq )
    );

    // ------------------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------------------
    // One request strobe, driven just after the clock edge
    task automatic issue(input logic is_write, input logic [15:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        #1;
        req = '{valid: 1'b1, write: is_write, addr: addr, wdata: wdata};
        @(posedge clk);
        #1;
        req.valid = 1'b0;
    endtask

    task automatic write_reg(input string name, input logic [15:0] addr,
                             input logic [31:0] data, input logic exp_err);
        i_checker.post_exact(name, exp_err, '0);
        issue(1'b1, addr, data);
        i_checker.wait_response(name);
    endtask

    task automatic read_reg(input string name, input logic [15:0] addr,
                            input logic exp_err, input logic [31:0] exp_data);
        i_checker.post_exact(name, exp_err, exp_data);
        issue(1'b0, addr, '0);
        i_checker.wait_response(name);
    endtask

    task automatic read_claim(input int t);
        i_checker.post_claim($sformatf("claim %0d", t), t);
        issue(1'b0, plic_base + 16'h0280 + 16'(4 * t), '0);
        i_checker.wait_response($sformatf("claim %0d", t));
    endtask

    // Interrupt controller writes that also update the checker model
    task automatic set_prio(input int s, input prio_t v);
        write_reg($sformatf("prio %0d write", s), plic_base + 16'(4 * s), 32'(v), 1'b0);
        i_checker.track_prio(s, v);
    endtask

    task automatic set_enable(input int t, input src_vec_t v);
        write_reg($sformatf("enable %0d write", t), plic_base + 16'h0100 + 16'(4 * t),
                  32'(v), 1'b0);
        i_checker.track_enable(t, v);
    endtask

    task automatic set_threshold(input int t, input prio_t v);
        write_reg($sformatf("threshold %0d write", t), plic_base + 16'h0200 + 16'(4 * t),
                  32'(v), 1'b0);
        i_checker.track_threshold(t, v);
    endtask

    task automatic set_ext(input logic [`NUM_EXT_SOURCES-1:0] v);
        @(posedge clk);
        #1;
        ext_irq = v;
        i_checker.track_ext(v);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int          cycles;
        logic [31:0] rnd;
        req     = '0;
        ext_irq = '0;
        seed    = 32'hd975b916;
        cycles  = 0;
        @(posedge clk);
        while (reset !== 1'b0 && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            i_checker.note_error("Reset was not released within 100 cycles");
        end

        i_checker.start_test("register_readback");
        for (int s = 1; s < `NUM_SOURCES; s++) begin
            set_prio(s, prio_t'(s));
            read_reg($sformatf("prio %0d", s), plic_base + 16'(4 * s), 1'b0, 32'(s));
        end
        for (int t = 0; t < `NUM_TARGETS; t++) begin
            set_enable(t, 8'ha5 ^ 8'(t * 8'h99));
            read_reg($sformatf("enable %0d", t), plic_base + 16'h0100 + 16'(4 * t), 1'b0,
                     32'(8'ha5 ^ 8'(t * 8'h99)));
            set_threshold(t, prio_t'(5 - 3 * t));
            read_reg($sformatf("threshold %0d", t), plic_base + 16'h0200 + 16'(4 * t), 1'b0,
                     32'(prio_t'(5 - 3 * t)));
        end
        write_reg("timer 0 compare write", timer_base + 16'h0008, 32'h1234_5678, 1'b0);
        read_reg("timer 0 compare", timer_base + 16'h0008, 1'b0, 32'h1234_5678);
        write_reg("timer 1 compare write", timer_base + 16'h0018, 32'h0bad_cafe, 1'b0);
        read_reg("timer 1 compare", timer_base + 16'h0018, 1'b0, 32'h0bad_cafe);
        i_checker.end_test();

        i_checker.start_test("unmapped_region");
        read_reg("unmapped read", unmapped, 1'b1, `ERR_RDATA);
        write_reg("unmapped write", unmapped + 16'h0abc, 32'h0000_0001, 1'b1);
        read_reg("unmapped read at top", unmapped + 16'h0ffc, 1'b1, `ERR_RDATA);
        i_checker.end_test();

        // Source 4 is external input bit 1
        i_checker.start_test("external_routing");
        set_threshold(0, 3'd0);
        set_threshold(1, 3'd0);
        set_enable(0, 8'h10);
        set_enable(1, 8'h00);
        set_prio(4, 3'd3);
        set_ext(5'b00010);
        i_checker.wait_irq("irq 0 rise", 0, 1'b1);
        i_checker.check_irq("irq 1 idle", 1, 1'b0);
        read_claim(0);
        read_claim(1);
        set_ext(5'b00000);
        i_checker.wait_irq("irq 0 fall", 0, 1'b0);
        i_checker.end_test();

        i_checker.start_test("threshold_masking");
        set_threshold(0, 3'd3);
        set_ext(5'b00010);
        repeat (3) @(posedge clk);
        i_checker.check_irq("irq 0 at equal threshold", 0, 1'b0);
        read_claim(0);
        set_threshold(0, 3'd7);
        repeat (3) @(posedge clk);
        i_checker.check_irq("irq 0 above threshold", 0, 1'b0);
        read_claim(0);
        set_ext(5'b00000);
        i_checker.end_test();

        i_checker.start_test("timer_interrupt");
        set_prio(1, 3'd2);
        set_enable(0, 8'h00);
        set_enable(1, 8'h02);
        set_threshold(1, 3'd0);
        write_reg("timer 0 compare write", timer_base + 16'h0008, 32'd30, 1'b0);
        write_reg("timer 0 counter write", timer_base, 32'd0, 1'b0);
        write_reg("timer 0 enable", timer_base + 16'h0004, 32'd1, 1'b0);
        i_checker.wait_irq("timer irq rise", 1, 1'b1);
        i_checker.post_at_least("timer 0 counter", 32'd30);
        issue(1'b0, timer_base, '0);
        i_checker.wait_response("timer 0 counter");
        write_reg("timer 0 disable", timer_base + 16'h0004, 32'd0, 1'b0);
        i_checker.wait_irq("timer irq fall", 1, 1'b0);
        i_checker.end_test();

        i_checker.start_test("random_arbitration");
        repeat (20) begin
            for (int s = 1; s < `NUM_SOURCES; s++) begin
                rnd = $random(seed);
                set_prio(s, rnd[2:0]);
            end
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                rnd = $random(seed);
                set_enable(t, rnd[7:0]);
                set_threshold(t, rnd[10:8]);
            end
            rnd = $random(seed);
            set_ext(rnd[4:0]);
            for (int t = 0; t < `NUM_TARGETS; t++) begin
                read_claim(t);
                i_checker.check_irq_model($sformatf("irq %0d level", t), t);
            end
        end
        i_checker.end_test();

        i_checker.print_summary();
        if (i_checker.error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- periph_subsystem.f
+incdir+design
design/reg_bus_pkg.sv
design/irq_pkg.sv
design/reg_demux.sv
design/err_responder.sv
design/periph_timer.sv
design/plic_regs.sv
design/plic_target.sv
design/periph_subsystem.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_periph_subsystem.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_periph_subsystem \
    -f periph_subsystem.f

./obj_dir/Vtb_periph_subsystem > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result line, see sim.log"
    exit 1
fi
exit 0
